/* bench/program_input.txt */
// each line holds kind, byte address and word in hex.
// kind 0 is a memory image word and kind 1 a word expected after halt.
// kind 2 gives the store count of the hart whose window holds the address.
0 00000000 10000100
0 00000004 20000005
0 00000008 30000104
0 0000000c 40000200
0 00000010 60000000
0 00000100 00000010
0 00000104 00000023
1 00000200 00000038
2 00000000 00000001
0 00001000 10000100
0 00001004 20000020
0 00001008 40000180
0 0000100c 30000180
0 00001010 40000184
0 00001014 60000000
0 00001100 7ffffff0
1 00001180 80000010
1 00001184 00000020
2 00001000 00000002
0 00002000 20000100
0 00002004 50000040
0 00002008 60000000
0 00002040 40000300
0 00002044 2000fe00
0 00002048 40000304
0 0000204c 50000008
1 00002300 00000100
1 00002304 ffffff00
2 00002000 00000002
0 00003000 10000200
0 00003004 30000204
0 00003008 40000208
0 0000300c 20007fff
0 00003010 4000020c
0 00003014 60000000
0 00003200 00001234
0 00003204 00004321
1 00003208 00005555
1 0000320c 0000d554
2 00003000 00000002

/* flist.f */
design/core_isa_pkg.sv
design/bus_pkg.sv
design/hart_core.sv
design/mem_controller.sv
design/apb_requester.sv
design/multicore_top.sv
bench/apb_memory.sv
bench/multicore_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the cluster testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
PASS_TEXT="PASS: all tests"

if ! verilator --binary --timing --assert -Wno-fatal -f flist.f \
        --top-module multicore_tb -Mdir obj_dir -o multicore_tb_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/multicore_tb_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -qx "$PASS_TEXT" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* bench/multicore_tb.sv */
`timescale 1ns/100ps

module multicore_tb;
    import bus_pkg::*;

    localparam int NUM_HARTS = 4;
    localparam int WINDOW_BITS = 12;
    localparam int MAX_WORDS = 192;
    localparam int HALT_TIMEOUT = 5000;

    logic CLK;
    logic rst;
    logic halt;
    logic psel;
    logic penable;
    logic pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic pready;

    logic [31:0] entries [0:MAX_WORDS-1];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_word [$];
    int stores_per_hart [0:NUM_HARTS-1];
    int writes_per_hart [0:NUM_HARTS-1];
    int total_stores;
    int write_count;
    int mismatch_count;
    int fail_count;

    // previous monitor cycle, for the APB phase rules.
    logic prev_psel;
    logic prev_penable;
    logic prev_done;
    logic prev_pwrite;
    logic [31:0] prev_paddr;
    logic [31:0] prev_pwdata;
    logic halt_seen;

    multicore_top #(
        .NUM_HARTS(NUM_HARTS)
    ) multicore_top_i (
        .CLK(CLK),
        .rst(rst),
        .halt(halt),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready)
    );

    apb_memory #(
        .WORDS(NUM_HARTS << (WINDOW_BITS - 2))
    ) mem_i (
        .CLK(CLK),
        .rst(rst),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready)
    );

    always #10 CLK = ~CLK;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            mismatch_count++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        fail_count++;
    endtask

    function automatic bit is_expected_addr(input logic [31:0] a);
        bit found;
        found = 1'b0;
        foreach (exp_addr[k]) begin
            if (exp_addr[k] == a) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // APB monitor, sampled at the falling edge where every signal is settled.
    always @(negedge CLK) begin
        int hart_idx;
        if (rst) begin
            prev_psel = 1'b0;
            prev_penable = 1'b0;
            prev_done = 1'b0;
            halt_seen = 1'b0;
        end else begin
            if (penable && !psel) begin
                report_failure("penable is high while psel is low");
            end
            if (penable && !prev_psel) begin
                report_failure("access phase started without a setup cycle");
            end
            if (penable && prev_done) begin
                report_failure("access phase went on after pready ended the transfer");
            end
            if (prev_psel && !prev_penable && !penable) begin
                report_failure("setup phase lasted more than one cycle");
            end
            if (psel && prev_psel && !prev_done) begin
                check_value("paddr", paddr, prev_paddr);
                check_value("pwrite", 32'(pwrite), 32'(prev_pwrite));
                if (pwrite) begin
                    check_value("pwdata", pwdata, prev_pwdata);
                end
            end
            if (psel && penable && pready) begin
                hart_idx = int'(paddr >> WINDOW_BITS);
                if (hart_idx >= NUM_HARTS || paddr[1:0] != 2'b00) begin
                    report_failure($sformatf("paddr %h lies outside every hart window", paddr));
                end else if (pwrite) begin
                    write_count++;
                    writes_per_hart[hart_idx]++;
                    if (!is_expected_addr(paddr)) begin
                        report_failure($sformatf("write to %h, which no expected word names",
                                                 paddr));
                    end
                end
            end
            if (halt && !halt_seen) begin
                halt_seen = 1'b1; // every store must already be on the bus.
                for (int h = 0; h < NUM_HARTS; h++) begin
                    check_value($sformatf("stores of hart %0d at halt", h),
                                writes_per_hart[h], stores_per_hart[h]);
                end
            end
            prev_done = psel && penable && pready;
            prev_psel = psel;
            prev_penable = penable;
            prev_pwrite = pwrite;
            prev_paddr = paddr;
            prev_pwdata = pwdata;
        end
    end

    initial begin
        int i;
        int hart_idx;
        int cycles;
        bit timed_out;
        CLK = 1'b0;
        rst = 1'b1;
        total_stores = 0;
        write_count = 0;
        mismatch_count = 0;
        fail_count = 0;
        timed_out = 1'b0;
        for (int h = 0; h < NUM_HARTS; h++) begin
            stores_per_hart[h] = 0;
            writes_per_hart[h] = 0;
        end
        for (int w = 0; w < MAX_WORDS; w++) begin
            entries[w] = '1; // marks the end of the file.
        end
        $readmemh("bench/program_input.txt", entries);

        @(posedge CLK);
        i = 0;
        while (i + 2 < MAX_WORDS && entries[i] <= 32'd2) begin
            case (entries[i])
                32'd0: mem_i.write_word(entries[i+1], entries[i+2]);
                32'd1: begin
                    exp_addr.push_back(entries[i+1]);
                    exp_word.push_back(entries[i+2]);
                end
                default: begin
                    hart_idx = int'(entries[i+1] >> WINDOW_BITS);
                    stores_per_hart[hart_idx] = int'(entries[i+2]);
                    total_stores += int'(entries[i+2]);
                end
            endcase
            i += 3;
        end
        if (exp_addr.size() == 0) begin
            report_failure("the data file holds no expected words");
        end

        repeat (9) @(posedge CLK);
        rst <= 1'b0;
        @(negedge CLK);
        check_value("psel", 32'(psel), 32'd0);
        check_value("penable", 32'(penable), 32'd0);
        check_value("halt", 32'(halt), 32'd0);

        cycles = 0;
        while (!halt && cycles < HALT_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (!halt) begin
            report_failure($sformatf("halt did not rise within %0d cycles", HALT_TIMEOUT));
            timed_out = 1'b1;
        end

        if (!timed_out) begin
            @(posedge CLK);
            @(negedge CLK);
            foreach (exp_addr[k]) begin
                check_value($sformatf("mem[%h]", exp_addr[k]),
                            mem_i.read_word(exp_addr[k]), exp_word[k]);
            end
            check_value("apb write count", write_count, total_stores);
        end

        $display("checks done with %0d mismatches and %0d other errors",
                 mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* bench/apb_memory.sv */
`timescale 1ns/100ps

module apb_memory #(
    parameter int WORDS = 4096
) (
    input  logic        CLK,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready
);
    localparam int ADDR_BITS = $clog2(WORDS) + 2;

    logic [31:0] mem [0:WORDS-1];
    integer seed = 32'hbbbd;
    logic in_range;

    assign in_range = (paddr >> ADDR_BITS) == 32'd0;

    // untouched words hold a value built from their own byte address.
    initial begin
        pready = 1'b0;
        prdata = '0;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = 32'hfeed_0000 ^ 32'(i << 2);
        end
    end

    always @(posedge CLK) begin
        if (rst) begin
            pready <= 1'b0;
            prdata <= '0;
        end else begin
            pready <= ($random(seed) & 32'sd3) != 32'sd0; // about one wait state in four.
            if (psel && penable && pready && pwrite && in_range) begin
                mem[paddr[ADDR_BITS-1:2]] = pwdata;
            end
            if (psel && in_range) begin
                prdata <= mem[paddr[ADDR_BITS-1:2]]; // settles during setup, valid in access.
            end
        end
    end

    task automatic write_word(input logic [31:0] byte_addr, input logic [31:0] data);
        mem[byte_addr[ADDR_BITS-1:2]] = data;
    endtask

    function automatic logic [31:0] read_word(input logic [31:0] byte_addr);
        return mem[byte_addr[ADDR_BITS-1:2]];
    endfunction

endmodule

/* design/multicore_top.sv */
`timescale 1ns/100ps

module multicore_top #(
    parameter int NUM_HARTS = 4
) (
    input  logic                       CLK,
    input  logic                       rst,
    output logic                       halt,
    output logic                       psel,
    output logic                       penable,
    output logic                       pwrite,
    output logic [bus_pkg::ADDR_W-1:0] paddr,
    output logic [bus_pkg::DATA_W-1:0] pwdata,
    input  logic [bus_pkg::DATA_W-1:0] prdata,
    input  logic                       pready
);
    import bus_pkg::*;

    logic [NUM_HARTS-1:0] hart_req;
    logic [NUM_HARTS-1:0] hart_we;
    logic [NUM_HARTS-1:0][ADDR_W-1:0] hart_addr;
    logic [NUM_HARTS-1:0][DATA_W-1:0] hart_wdata;
    logic [NUM_HARTS-1:0] hart_ready;
    logic [DATA_W-1:0] hart_rdata;
    logic [NUM_HARTS-1:0] hart_halted;

    logic ctrl_req;
    logic ctrl_we;
    logic [ADDR_W-1:0] ctrl_addr;
    logic [DATA_W-1:0] ctrl_wdata;
    logic ctrl_ready;
    logic [DATA_W-1:0] ctrl_rdata;

    assign halt = &hart_halted; // the run ends once every hart has stopped.

    mem_controller #(
        .NUM_HARTS(NUM_HARTS)
    ) mc (
        .CLK(CLK),
        .rst(rst),
        .hart_req(hart_req),
        .hart_we(hart_we),
        .hart_addr(hart_addr),
        .hart_wdata(hart_wdata),
        .hart_ready(hart_ready),
        .hart_rdata(hart_rdata),
        .req(ctrl_req),
        .we(ctrl_we),
        .addr(ctrl_addr),
        .wdata(ctrl_wdata),
        .ready(ctrl_ready),
        .rdata(ctrl_rdata)
    );

    for (genvar i = 0; i < NUM_HARTS; i++) begin : g_hart
        hart_core #(
            .HART_ID(i)
        ) hart (
            .CLK(CLK),
            .rst(rst),
            .req(hart_req[i]),
            .we(hart_we[i]),
            .addr(hart_addr[i]),
            .wdata(hart_wdata[i]),
            .ready(hart_ready[i]),
            .rdata(hart_rdata),
            .halted(hart_halted[i])
        );
    end

    apb_requester bt (
        .CLK(CLK),
        .rst(rst),
        .req(ctrl_req),
        .we(ctrl_we),
        .addr(ctrl_addr),
        .wdata(ctrl_wdata),
        .ready(ctrl_ready),
        .rdata(ctrl_rdata),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready)
    );

endmodule

/* design/apb_requester.sv */
`timescale 1ns/100ps

module apb_requester (
    input  logic                       CLK,
    input  logic                       rst,
    input  logic                       req,
    input  logic                       we,
    input  logic [bus_pkg::ADDR_W-1:0] addr,
    input  logic [bus_pkg::DATA_W-1:0] wdata,
    output logic                       ready,
    output logic [bus_pkg::DATA_W-1:0] rdata,
    output logic                       psel,
    output logic                       penable,
    output logic                       pwrite,
    output logic [bus_pkg::ADDR_W-1:0] paddr,
    output logic [bus_pkg::DATA_W-1:0] pwdata,
    input  logic [bus_pkg::DATA_W-1:0] prdata,
    input  logic                       pready
);
    import bus_pkg::*;

    apb_state_t state;

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= SETUP;
                    end
                end
                SETUP: begin
                    state <= ACCESS;
                end
                ACCESS: begin
                    if (pready) begin
                        state <= IDLE; // transfer done, upstream sees ready now.
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // the request is captured once and held through setup and access.
    always_ff @(posedge CLK) begin
        if (state == IDLE && req) begin
            pwrite <= we;
            paddr <= addr;
            pwdata <= wdata;
        end
    end

    assign psel = (state != IDLE);
    assign penable = (state == ACCESS);
    assign ready = penable && pready;
    assign rdata = prdata;

    // a request still high after ready would start the same transfer again.
    a_req_released: assert property (@(posedge CLK) disable iff (rst)
        ready |=> !req)
        else $error("upstream request stayed high after ready");

    a_paddr_stable: assert property (@(posedge CLK) disable iff (rst)
        psel |-> req && paddr == addr && pwrite == we && pwdata == wdata)
        else $error("paddr, pwrite or pwdata left the open request inside a transfer");

endmodule

/* design/mem_controller.sv */
`timescale 1ns/100ps

module mem_controller #(
    parameter int NUM_HARTS = 4
) (
    input  logic                                      CLK,
    input  logic                                      rst,
    input  logic [NUM_HARTS-1:0]                      hart_req,
    input  logic [NUM_HARTS-1:0]                      hart_we,
    input  logic [NUM_HARTS-1:0][bus_pkg::ADDR_W-1:0] hart_addr,
    input  logic [NUM_HARTS-1:0][bus_pkg::DATA_W-1:0] hart_wdata,
    output logic [NUM_HARTS-1:0]                      hart_ready,
    output logic [bus_pkg::DATA_W-1:0]                hart_rdata,
    output logic                                      req,
    output logic                                      we,
    output logic [bus_pkg::ADDR_W-1:0]                addr,
    output logic [bus_pkg::DATA_W-1:0]                wdata,
    input  logic                                      ready,
    input  logic [bus_pkg::DATA_W-1:0]                rdata
);
    import bus_pkg::*;

    localparam int IDX_W = idx_w(NUM_HARTS);

    logic busy;
    logic [IDX_W-1:0] grant;
    logic [IDX_W-1:0] last;
    logic [IDX_W-1:0] pick;
    logic pick_valid;

    // search starts just after the last winner, so every hart gets a turn.
    always_comb begin
        int cand;
        pick = last;
        pick_valid = 1'b0;
        for (int k = 1; k <= NUM_HARTS; k++) begin
            cand = (int'(last) + k) % NUM_HARTS;
            if (!pick_valid && hart_req[cand]) begin
                pick = IDX_W'(cand);
                pick_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            busy <= 1'b0;
            grant <= '0;
            last <= IDX_W'(NUM_HARTS - 1); // hart 0 wins first.
        end else if (busy) begin
            if (ready) begin
                busy <= 1'b0;
                last <= grant;
            end
        end else if (pick_valid) begin
            busy <= 1'b1;
            grant <= pick;
        end
    end

    assign req = busy;
    assign we = hart_we[grant];
    assign addr = hart_addr[grant];
    assign wdata = hart_wdata[grant];
    assign hart_rdata = rdata; // only the granted hart samples it.

    always_comb begin
        hart_ready = '0;
        hart_ready[grant] = busy && ready;
    end

    a_one_ready: assert property (@(posedge CLK) disable iff (rst)
        $onehot0(hart_ready) && ((hart_ready & ~hart_req) == '0))
        else $error("ready went to more than one hart or to a hart without a request");

    a_grant_locked: assert property (@(posedge CLK) disable iff (rst)
        busy && !ready |=> busy && $stable(grant) && hart_req[grant])
        else $error("grant moved while a transfer was open");

endmodule

/* design/hart_core.sv */
`timescale 1ns/100ps

module hart_core #(
    parameter int HART_ID = 0
) (
    input  logic                       CLK,
    input  logic                       rst,
    output logic                       req,
    output logic                       we,
    output logic [bus_pkg::ADDR_W-1:0] addr,
    output logic [bus_pkg::DATA_W-1:0] wdata,
    input  logic                       ready,
    input  logic [bus_pkg::DATA_W-1:0] rdata,
    output logic                       halted
);
    import core_isa_pkg::*;
    import bus_pkg::*;

    // base address of this hart's private window.
    localparam logic [ADDR_W-1:0] WINDOW_BASE = ADDR_W'(HART_ID) << WINDOW_BITS;

    hart_state_t state;
    logic [WINDOW_BITS-1:0] pc;
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] ir;
    opcode_t op;
    logic [IMM_BITS-1:0] imm;
    logic [WINDOW_BITS-1:0] local_addr;
    logic [DATA_W-1:0] imm_ext;

    assign op = opcode_t'(ir[OPC_MSB:OPC_LSB]);
    assign imm = ir[IMM_BITS-1:0];
    assign local_addr = imm[WINDOW_BITS-1:0];
    assign imm_ext = {{(DATA_W-IMM_BITS){imm[IMM_BITS-1]}}, imm};
    assign halted = (state == HALTED);

    // acc only changes outside an open request, so it can feed the bus directly.
    assign wdata = acc;

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= FETCH;
            pc <= RESET_PC;
            acc <= '0;
            req <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (!req) begin
                        req <= 1'b1; // open the instruction fetch.
                    end else if (ready) begin
                        req <= 1'b0;
                        state <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    case (op)
                        OP_LOAD, OP_ADD, OP_STORE: begin
                            req <= 1'b1; // one data transfer follows.
                            state <= MEM_WAIT;
                        end
                        OP_ADDI: begin
                            acc <= acc + imm_ext;
                            pc <= pc + PC_STEP;
                            state <= FETCH;
                        end
                        OP_JUMP: begin
                            pc <= local_addr;
                            state <= FETCH;
                        end
                        OP_HALT: begin
                            state <= HALTED;
                        end
                        default: begin
                            state <= HALTED; // unknown opcodes stop the hart.
                        end
                    endcase
                end
                MEM_WAIT: begin
                    if (ready) begin
                        req <= 1'b0;
                        pc <= pc + PC_STEP;
                        state <= FETCH;
                        if (op == OP_LOAD) begin
                            acc <= rdata;
                        end else if (op == OP_ADD) begin
                            acc <= acc + rdata;
                        end
                    end
                end
                default: begin
                    state <= HALTED; // HALTED is terminal until reset.
                end
            endcase
        end
    end

    // request payload, loaded in the cycle before req rises.
    always_ff @(posedge CLK) begin
        if (state == FETCH && !req) begin
            addr <= WINDOW_BASE | ADDR_W'(pc);
            we <= 1'b0;
        end
        if (state == FETCH && req && ready) begin
            ir <= rdata;
        end
        if (state == EXECUTE) begin
            addr <= WINDOW_BASE | ADDR_W'(local_addr);
            we <= (op == OP_STORE);
        end
    end

    // the controller and the translator rely on a request staying put until served.
    a_req_held: assert property (@(posedge CLK) disable iff (rst)
        req && !ready |=> req && $stable(addr) && $stable(we) && $stable(wdata))
        else $error("hart %0d changed its request before ready", HART_ID);

    a_halted_quiet: assert property (@(posedge CLK) disable iff (rst)
        halted |=> halted && !req)
        else $error("hart %0d left HALTED or raised req after halting", HART_ID);

endmodule

/* design/bus_pkg.sv */
package bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // translator states for the APB requester port.
    typedef enum logic [1:0] {
        IDLE   = 2'b00, // no transfer, psel low.
        SETUP  = 2'b01, // psel high for one cycle.
        ACCESS = 2'b10  // psel and penable high until pready.
    } apb_state_t;

    // width of an index over n requesters.
    // A single requester still needs one bit so that the index is a legal vector.
    function automatic int idx_w(input int n);
        int w;
        w = 1;
        if (n > 1) begin
            w = $clog2(n);
        end
        return w;
    endfunction

endpackage

/* design/core_isa_pkg.sv */
package core_isa_pkg;

    // each hart owns a 4 KiB window; every local address and the PC use this width.
    localparam int WINDOW_BITS = 12;

    // immediate or operand address, taken from the low bits of the instruction.
    localparam int IMM_BITS = 16;

    // the opcode sits in the top nibble of the instruction.
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 28;

    // start address, relative to the hart window.
    localparam logic [WINDOW_BITS-1:0] RESET_PC = '0;

    // the PC steps one 32-bit word at a time.
    localparam logic [WINDOW_BITS-1:0] PC_STEP = 12'd4;

    typedef enum logic [3:0] {
        OP_LOAD  = 4'h1, // acc = mem[imm].
        OP_ADDI  = 4'h2, // acc = acc + sign extended imm.
        OP_ADD   = 4'h3, // acc = acc + mem[imm].
        OP_STORE = 4'h4, // mem[imm] = acc.
        OP_JUMP  = 4'h5, // pc = imm.
        OP_HALT  = 4'h6
    } opcode_t;

    // any other opcode value is treated like halt by the hart.

    typedef enum logic [1:0] {
        FETCH    = 2'b00,
        EXECUTE  = 2'b01,
        MEM_WAIT = 2'b10,
        HALTED   = 2'b11
    } hart_state_t;

endpackage
